/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      := tb_top
FILELIST := compile.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* compile.f */
+incdir+hdl
hdl/ctrl_pkg.sv
hdl/ctrl_stage_regs.sv
hdl/d_bypass.sv
hdl/x_decode.sv
hdl/x_forward.sv
hdl/wf_decode.sv
hdl/pipe_ctrl_top.sv
dv/ctrl_checker.sv
dv/tb_top.sv

/* dv/ctrl_checker.sv */
`timescale 1ns/100ps

module ctrl_checker (
  input  logic        clk,
  input  logic        check_en,
  input  logic [55:0] exp_fields,
  input  logic        rs1_bypass_d,
  input  logic        rs2_bypass_d,
  input  logic [3:0]  alu_op,
  input  logic        imm_sel,
  input  logic        br_un,
  input  logic        redirect,
  input  logic [1:0]  rs1_fwd,
  input  logic [1:0]  rs2_fwd,
  input  logic [1:0]  store_data_sel,
  input  logic [1:0]  op_a_sel,
  input  logic        rf_we,
  input  logic [1:0]  wb_sel,
  input  logic [2:0]  ldx_sel,
  input  logic        mem_store,
  output logic [31:0] error_count,
  output logic [31:0] check_count
);

  int errors = 0;
  int checks = 0;

  assign error_count = errors;
  assign check_count = checks;

  // One hex digit per field in the data file
  task automatic compare_field(input string name, input logic [3:0] got,
                               input logic [3:0] want);
    if (got !== want) begin
      errors = errors + 1;
      $display("Mismatch at %0d ns: %s is %0h, expected %0h", $time, name, got, want);
    end
  endtask

  // Inputs change on the falling edge, so outputs are settled here
  always @(posedge clk) begin
    if (check_en) begin
      checks = checks + 1;
      compare_field("rs1_bypass_d", 4'(rs1_bypass_d), exp_fields[55:52]);
      compare_field("rs2_bypass_d", 4'(rs2_bypass_d), exp_fields[51:48]);
      compare_field("alu_op", alu_op, exp_fields[47:44]);  // X stage
      compare_field("imm_sel", 4'(imm_sel), exp_fields[43:40]);
      compare_field("br_un", 4'(br_un), exp_fields[39:36]);
      compare_field("redirect", 4'(redirect), exp_fields[35:32]);
      compare_field("rs1_fwd", 4'(rs1_fwd), exp_fields[31:28]);
      compare_field("rs2_fwd", 4'(rs2_fwd), exp_fields[27:24]);
      compare_field("store_data_sel", 4'(store_data_sel), exp_fields[23:20]);
      compare_field("op_a_sel", 4'(op_a_sel), exp_fields[19:16]);
      compare_field("rf_we", 4'(rf_we), exp_fields[15:12]);  // WF stage
      compare_field("wb_sel", 4'(wb_sel), exp_fields[11:8]);
      compare_field("ldx_sel", 4'(ldx_sel), exp_fields[7:4]);
      compare_field("mem_store", 4'(mem_store), exp_fields[3:0]);
    end
  end

endmodule

/* dv/ctrl_testdata.hex */
// instr_d _ br_eq br_lt _ rs1_bypass_d rs2_bypass_d _ alu_op imm_sel br_un redirect
// _ rs1_fwd rs2_fwd store_data_sel op_a_sel _ rf_we wb_sel ldx_sel mem_store
003100B3_00_00_0100_0000_1100 // add x1, x2, x3
40508233_00_00_0000_0000_1100 // sub x4, x1, x5
00022303_00_00_1000_1000_1100 // lw x6, 0(x4)
001303B3_00_00_0100_1000_1100 // add x7, x6, x1
0013C403_00_00_0000_2000_1000 // lbu x8, 1(x7)
00842423_00_00_0100_1000_1100 // sw x8, 8(x8)
00001483_00_00_0100_2222_1030 // lh x9, 0(x0)
00000583_00_00_0100_0000_0101 // lb x11, 0(x0)
0004D603_00_10_0100_0000_1020 // lhu x12, 0(x9)
009666B3_00_00_0100_0000_1040 // or x13, x12, x9
00C6C733_00_01_3000_2000_1010 // xor x14, x13, x12
40375793_00_00_4000_1000_1100 // srai x15, x14, 3
0017B033_00_00_7100_1000_1100 // sltu x0, x15, x1
00007833_00_00_9000_1000_1100 // and x16, x0, x0
00001297_00_00_2000_0000_1100 // auipc x5, 1
12345337_00_00_0100_0001_1100 // lui x6, 0x12345
008000EF_00_00_A100_0000_1100 // jal x1
401080B3_00_00_0101_0001_1100 // sub x1, x1, x1 squashed
00008067_00_10_0100_0000_1200 // jalr x0, 0(x1)
401080B3_00_00_0101_0000_1100
00000463_00_00_0100_0000_1200 // beq
00000463_01_00_0100_0001_1100
401080B3_10_00_0101_0001_0100
00001463_11_00_0100_0000_0100 // bne
00001463_11_00_0100_0001_1100
401080B3_00_00_0101_0001_0100
00004463_00_00_0100_0000_0100 // blt
00004463_10_00_0100_0001_1100
401080B3_01_00_0101_0001_0100
00005463_00_00_0100_0000_0100 // bge
00005463_01_00_0100_0001_1100
401080B3_10_00_0101_0001_0100
00006463_00_00_0100_0000_0100 // bltu
00006463_00_00_0110_0001_1100
401080B3_11_00_0111_0001_0100
00007463_00_00_0100_0000_0100 // bgeu
00007463_11_00_0110_0001_1100
401080B3_00_00_0111_0001_0100
00000013_00_00_0100_0000_0100
00000013_00_00_0100_0000_1100
FFFFFFFF_FF_FF_FFFF_FFFF_FFFF // end marker

/* dv/tb_top.sv */
`timescale 1ns/100ps
`include "ctrl_settings.svh"

module tb_top;
  import ctrl_pkg::*;

  localparam int          CLK_PERIOD = 20;
  localparam int          MAX_VECS   = 64;
  localparam logic [95:0] END_MARK   = '1;  // Last line of the data file

  logic                  clk;
  logic                  rst;
  logic [`CTRL_XLEN-1:0] instr_d;
  logic                  br_eq;
  logic                  br_lt;
  logic                  rs1_bypass_d;
  logic                  rs2_bypass_d;
  alu_op_e               alu_op;
  logic                  imm_sel;
  logic                  br_un;
  logic                  redirect;
  fwd_sel_e              rs1_fwd;
  fwd_sel_e              rs2_fwd;
  fwd_sel_e              store_data_sel;
  op_a_sel_e             op_a_sel;
  logic                  rf_we;
  wb_sel_e               wb_sel;
  ldx_sel_e              ldx_sel;
  logic                  mem_store;

  logic                  check_en;
  logic [55:0]           exp_fields;
  logic [31:0]           error_count;
  logic [31:0]           check_count;
  logic [95:0]           vectors [0:MAX_VECS-1];
  int                    num_vecs;
  logic                  vectors_loaded;

  pipe_ctrl_top uut (.*);

  ctrl_checker u_checker (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Zero when the end marker is missing
  function automatic int count_vectors();
    int n;
    n = 0;
    while ((n < MAX_VECS) && (vectors[n] !== END_MARK)) begin
      n++;
    end
    return (n < MAX_VECS) ? n : 0;
  endfunction

  initial begin
    rst            = 1'b1;
    instr_d        = `CTRL_NOP;
    br_eq          = 1'b0;
    br_lt          = 1'b0;
    check_en       = 1'b0;
    exp_fields     = '0;
    vectors_loaded = 1'b0;
    $readmemh("dv/ctrl_testdata.hex", vectors);
    num_vecs       = count_vectors();
    vectors_loaded = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < num_vecs; i++) begin
      instr_d    = vectors[i][95:64];
      br_eq      = vectors[i][60];  // Flags belong to the instruction now in X
      br_lt      = vectors[i][56];
      exp_fields = vectors[i][55:0];
      check_en   = 1'b1;
      @(negedge clk);
    end
    check_en = 1'b0;
    if (num_vecs == 0) begin
      $display("No test records with an end marker were read from dv/ctrl_testdata.hex");
    end
    $display("Records: %0d  checks: %0d  errors: %0d", num_vecs, check_count, error_count);
    if ((num_vecs > 0) && (error_count == 0) && (check_count == num_vecs)) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Run length is the record count plus reset and slack
  initial begin
    wait (vectors_loaded);
    #((num_vecs + 10) * CLK_PERIOD);
    $display("Timeout: stimulus did not finish within %0d clock cycles", num_vecs + 10);
    $display("Regression failed");
    $finish;
  end

endmodule

/* hdl/ctrl_pkg.sv */
`include "ctrl_settings.svh"

package ctrl_pkg;

  // Opcode bits [6:2]
  typedef enum logic [`CTRL_OPC_W-1:0] {
    OPC_LOAD   = 5'b00000,
    OPC_ITYPE  = 5'b00100,
    OPC_AUIPC  = 5'b00101,
    OPC_STORE  = 5'b01000,
    OPC_RTYPE  = 5'b01100,
    OPC_LUI    = 5'b01101,
    OPC_BRANCH = 5'b11000,
    OPC_JALR   = 5'b11001,
    OPC_JAL    = 5'b11011
  } opcode_e;

  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } branch_fn_e;

  typedef enum logic [2:0] {
    LD_LB  = 3'b000,
    LD_LH  = 3'b001,
    LD_LW  = 3'b010,
    LD_LBU = 3'b100,
    LD_LHU = 3'b101
  } load_fn_e;

  typedef enum logic [`CTRL_ALU_W-1:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLL    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_SLT    = 4'd8,
    ALU_SLTU   = 4'd9,
    ALU_PASS_B = 4'd10  // lui
  } alu_op_e;

  typedef enum logic [1:0] {WB_MEM = 2'd0, WB_ALU = 2'd1, WB_PC4 = 2'd2} wb_sel_e;

  typedef enum logic [2:0] {
    LDX_WORD   = 3'd0,
    LDX_HALF_U = 3'd1,
    LDX_HALF_S = 3'd2,
    LDX_BYTE_U = 3'd3,
    LDX_BYTE_S = 3'd4
  } ldx_sel_e;

  typedef enum logic [1:0] {FWD_RF = 2'd0, FWD_ALU = 2'd1, FWD_MEM = 2'd2} fwd_sel_e;

  typedef enum logic [1:0] {OPA_REG = 2'd0, OPA_PC = 2'd1, OPA_MEM = 2'd2} op_a_sel_e;

endpackage

/* hdl/ctrl_settings.svh */
`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

`define CTRL_XLEN   32
`define CTRL_REG_W  5
`define CTRL_OPC_W  5
`define CTRL_ALU_W  4

`define CTRL_NOP    32'h0000_0013  // addi x0, x0, 0

// Field positions inside an instruction word
`define CTRL_OPC_LSB 2
`define CTRL_RD_LSB  7
`define CTRL_F3_LSB  12
`define CTRL_RS1_LSB 15
`define CTRL_RS2_LSB 20
`define CTRL_F7_B30  30

`endif

/* hdl/ctrl_stage_regs.sv */
`timescale 1ns/100ps
`include "ctrl_settings.svh"

module ctrl_stage_regs (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [`CTRL_XLEN-1:0] instr_d,
  input  logic                 redirect,
  output logic [`CTRL_XLEN-1:0] instr_x,
  output logic [`CTRL_XLEN-1:0] instr_wf
);

  logic [`CTRL_XLEN-1:0] instr_x_next;

  // The instruction behind a redirect is the wrong path
  assign instr_x_next = redirect ? `CTRL_NOP : instr_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      instr_x  <= `CTRL_NOP;
      instr_wf <= `CTRL_NOP;
    end else begin
      instr_x  <= instr_x_next;
      instr_wf <= instr_x;  // X never stalls, so WF just follows
    end
  end

  // Redirect comes from the X decoder and must squash the D slot
  a_bubble_after_redirect : assert property (
    @(posedge clk) disable iff (rst)
    redirect |=> (instr_x == `CTRL_NOP)
  ) else $error("instr_x is not a NOP after redirect");

endmodule

/* hdl/d_bypass.sv */
`timescale 1ns/100ps
`include "ctrl_settings.svh"

module d_bypass (
  input  logic [`CTRL_XLEN-1:0] instr_d,
  input  logic [`CTRL_XLEN-1:0] instr_wf,
  output logic                  rs1_bypass_d,
  output logic                  rs2_bypass_d
);
  import ctrl_pkg::*;

  opcode_e                opc_wf;
  logic [`CTRL_REG_W-1:0] rd_wf;
  logic [`CTRL_REG_W-1:0] rs1_d;
  logic [`CTRL_REG_W-1:0] rs2_d;
  logic                   wf_writes;

  assign opc_wf = opcode_e'(instr_wf[`CTRL_OPC_LSB +: `CTRL_OPC_W]);
  assign rd_wf  = instr_wf[`CTRL_RD_LSB +: `CTRL_REG_W];
  assign rs1_d  = instr_d[`CTRL_RS1_LSB +: `CTRL_REG_W];
  assign rs2_d  = instr_d[`CTRL_RS2_LSB +: `CTRL_REG_W];

  // Stores and branches have no rd, x0 is never written
  assign wf_writes = (opc_wf != OPC_STORE) && (opc_wf != OPC_BRANCH) &&
                     (rd_wf != '0);

  // Regfile write lands at the clock edge, D reads the bypassed value instead
  assign rs1_bypass_d = wf_writes && (rd_wf == rs1_d);
  assign rs2_bypass_d = wf_writes && (rd_wf == rs2_d);

endmodule

/* hdl/pipe_ctrl_top.sv */
`timescale 1ns/100ps
`include "ctrl_settings.svh"

module pipe_ctrl_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`CTRL_XLEN-1:0] instr_d,
  input  logic                  br_eq,
  input  logic                  br_lt,
  output logic                  rs1_bypass_d,    // D stage
  output logic                  rs2_bypass_d,
  output ctrl_pkg::alu_op_e     alu_op,          // X stage
  output logic                  imm_sel,
  output logic                  br_un,
  output logic                  redirect,
  output ctrl_pkg::fwd_sel_e    rs1_fwd,
  output ctrl_pkg::fwd_sel_e    rs2_fwd,
  output ctrl_pkg::fwd_sel_e    store_data_sel,
  output ctrl_pkg::op_a_sel_e   op_a_sel,
  output logic                  rf_we,           // WF stage
  output ctrl_pkg::wb_sel_e     wb_sel,
  output ctrl_pkg::ldx_sel_e    ldx_sel,
  output logic                  mem_store
);

  logic [`CTRL_XLEN-1:0] instr_x;
  logic [`CTRL_XLEN-1:0] instr_wf;

  ctrl_stage_regs u_stage_regs (.clk, .rst, .instr_d, .redirect, .instr_x, .instr_wf);

  d_bypass u_d_bypass (.instr_d, .instr_wf, .rs1_bypass_d, .rs2_bypass_d);

  x_decode u_x_decode (
    .instr_x, .br_eq, .br_lt, .alu_op, .imm_sel, .br_un, .redirect
  );

  x_forward u_x_forward (
    .instr_x, .instr_wf, .rs1_fwd, .rs2_fwd, .store_data_sel, .op_a_sel
  );

  wf_decode u_wf_decode (.instr_wf, .rf_we, .wb_sel, .ldx_sel, .mem_store);

endmodule

/* hdl/wf_decode.sv */
`timescale 1ns/100ps
`include "ctrl_settings.svh"

module wf_decode (
  input  logic [`CTRL_XLEN-1:0] instr_wf,
  output logic                  rf_we,
  output ctrl_pkg::wb_sel_e     wb_sel,
  output ctrl_pkg::ldx_sel_e    ldx_sel,
  output logic                  mem_store
);
  import ctrl_pkg::*;

  opcode_e  opc;
  load_fn_e ld_fn;

  assign opc   = opcode_e'(instr_wf[`CTRL_OPC_LSB +: `CTRL_OPC_W]);
  assign ld_fn = load_fn_e'(instr_wf[`CTRL_F3_LSB +: 3]);

  assign mem_store = (opc == OPC_STORE);  // Memory write strobe for the datapath

  always_comb begin
    rf_we   = 1'b0;
    wb_sel  = WB_ALU;
    ldx_sel = LDX_WORD;
    case (opc)
      OPC_RTYPE, OPC_ITYPE, OPC_AUIPC, OPC_LUI: begin
        rf_we = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        rf_we  = 1'b1;
        wb_sel = WB_PC4;  // Link address
      end
      OPC_LOAD: begin
        rf_we  = 1'b1;
        wb_sel = WB_MEM;
        case (ld_fn)
          LD_LB:   ldx_sel = LDX_BYTE_S;
          LD_LBU:  ldx_sel = LDX_BYTE_U;
          LD_LH:   ldx_sel = LDX_HALF_S;
          LD_LHU:  ldx_sel = LDX_HALF_U;
          default: ldx_sel = LDX_WORD;
        endcase
      end
      default: rf_we = 1'b0;  // Store, branch, anything unknown
    endcase
  end

endmodule

/* hdl/x_decode.sv */
`timescale 1ns/100ps
`include "ctrl_settings.svh"

module x_decode (
  input  logic [`CTRL_XLEN-1:0] instr_x,
  input  logic                  br_eq,
  input  logic                  br_lt,
  output ctrl_pkg::alu_op_e     alu_op,
  output logic                  imm_sel,
  output logic                  br_un,
  output logic                  redirect
);
  import ctrl_pkg::*;

  opcode_e    opc;
  branch_fn_e br_fn;
  logic [2:0] funct3;
  logic       bit30;
  logic       br_taken;

  assign opc    = opcode_e'(instr_x[`CTRL_OPC_LSB +: `CTRL_OPC_W]);
  assign funct3 = instr_x[`CTRL_F3_LSB +: 3];
  assign br_fn  = branch_fn_e'(funct3);
  assign bit30  = instr_x[`CTRL_F7_B30];

  assign imm_sel = (opc != OPC_RTYPE);  // Only R-type takes rs2 as operand B
  assign br_un   = (opc == OPC_BRANCH) && ((br_fn == BR_BLTU) || (br_fn == BR_BGEU));

  always_comb begin
    alu_op = ALU_ADD;  // Loads, stores, branches, jumps, auipc
    if (opc == OPC_LUI) begin
      alu_op = ALU_PASS_B;
    end else if ((opc == OPC_RTYPE) || (opc == OPC_ITYPE)) begin
      case (funct3)
        3'b000:  alu_op = (opc == OPC_RTYPE && bit30) ? ALU_SUB : ALU_ADD;  // No subi
        3'b001:  alu_op = ALU_SLL;
        3'b010:  alu_op = ALU_SLT;
        3'b011:  alu_op = ALU_SLTU;
        3'b100:  alu_op = ALU_XOR;
        3'b101:  alu_op = bit30 ? ALU_SRA : ALU_SRL;  // Shift type in bit 30 for both
        3'b110:  alu_op = ALU_OR;
        default: alu_op = ALU_AND;
      endcase
    end
  end

  // Comparator already runs signed or unsigned per br_un
  always_comb begin
    br_taken = 1'b0;
    if (opc == OPC_BRANCH) begin
      case (br_fn)
        BR_BEQ:          br_taken = br_eq;
        BR_BNE:          br_taken = !br_eq;
        BR_BLT, BR_BLTU: br_taken = br_lt;
        BR_BGE, BR_BGEU: br_taken = !br_lt;
        default:         br_taken = 1'b0;  // Reserved funct3
      endcase
    end
  end

  // Target is the ALU result for every redirect
  assign redirect = (opc == OPC_JAL) || (opc == OPC_JALR) || br_taken;

  always_comb begin
    if (br_un) begin
      a_br_un_only_branch : assert (opc == OPC_BRANCH)
        else $error("br_un high outside a branch");
    end
  end

endmodule

/* hdl/x_forward.sv */
`timescale 1ns/100ps
`include "ctrl_settings.svh"

module x_forward (
  input  logic [`CTRL_XLEN-1:0] instr_x,
  input  logic [`CTRL_XLEN-1:0] instr_wf,
  output ctrl_pkg::fwd_sel_e    rs1_fwd,
  output ctrl_pkg::fwd_sel_e    rs2_fwd,
  output ctrl_pkg::fwd_sel_e    store_data_sel,
  output ctrl_pkg::op_a_sel_e   op_a_sel
);
  import ctrl_pkg::*;

  opcode_e                opc_x;
  opcode_e                opc_wf;
  logic [`CTRL_REG_W-1:0] rd_wf;
  logic [`CTRL_REG_W-1:0] rs1_x;
  logic [`CTRL_REG_W-1:0] rs2_x;
  logic                   wf_writer;
  logic                   wf_load;
  logic                   x_store;

  // Load results come from memory data, everything else from the WF ALU result
  function automatic fwd_sel_e pick_fwd(input logic hit, input logic from_load);
    if (!hit) begin
      return FWD_RF;
    end
    return from_load ? FWD_MEM : FWD_ALU;
  endfunction

  assign opc_x  = opcode_e'(instr_x[`CTRL_OPC_LSB +: `CTRL_OPC_W]);
  assign opc_wf = opcode_e'(instr_wf[`CTRL_OPC_LSB +: `CTRL_OPC_W]);
  assign rd_wf  = instr_wf[`CTRL_RD_LSB +: `CTRL_REG_W];
  assign rs1_x  = instr_x[`CTRL_RS1_LSB +: `CTRL_REG_W];
  assign rs2_x  = instr_x[`CTRL_RS2_LSB +: `CTRL_REG_W];

  assign wf_writer = (opc_wf != OPC_STORE) && (opc_wf != OPC_BRANCH) && (rd_wf != '0);
  assign wf_load   = (opc_wf == OPC_LOAD);
  assign x_store   = (opc_x == OPC_STORE);

  assign rs1_fwd        = pick_fwd(wf_writer && (rd_wf == rs1_x), wf_load);
  assign rs2_fwd        = pick_fwd(wf_writer && (rd_wf == rs2_x), wf_load);
  assign store_data_sel = pick_fwd(x_store && wf_writer && (rd_wf == rs2_x), wf_load);

  always_comb begin
    if ((opc_x == OPC_BRANCH) || (opc_x == OPC_JAL) || (opc_x == OPC_AUIPC)) begin
      op_a_sel = OPA_PC;
    end else if (x_store && wf_load && (rd_wf == rs1_x) && (rd_wf != '0)) begin
      op_a_sel = OPA_MEM;  // Store address base from a just-loaded pointer
    end else begin
      op_a_sel = OPA_REG;
    end
  end

  always_comb begin
    a_store_sel_only_store : assert (x_store || (store_data_sel == FWD_RF))
      else $error("store_data_sel forwards outside a store");
  end

endmodule
